// ==== src/soc_pkg.sv ====
// SoC shared definitions
package soc_pkg;

	// --------------------
	// Main bus
	// --------------------

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = 4;

	// Regions keyed by address bits 31:29
	typedef enum logic [2:0] {
		REGION_DEFAULT = 3'b000,
		REGION_BRAM    = 3'b001,
		REGION_CSR     = 3'b100
	} region_e;

	// Marker word of the unpopulated region
	localparam logic [DATA_W-1:0] DEFAULT_RD_DATA = 32'hABADFACE;

	// 4096 words of on-chip RAM
	localparam int BRAM_ADR_W = 12;

	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
		logic [SEL_W-1:0]  sel;
		logic              we;
		logic              cyc;
		logic              stb;
	} bus_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] dat;
		logic              ack;
	} bus_rsp_t;

	// --------------------
	// CSR bus
	// --------------------

	// Bank in the top 4 bits, register index below
	localparam int CSR_ADR_W = 14;

	typedef struct packed {
		logic [CSR_ADR_W-1:0] a;
		logic                 we;
		logic [DATA_W-1:0]    dw;
	} csr_req_t;

	localparam logic [3:0] CSR_BANK_SYSCTL = 4'h1;

	typedef enum logic [9:0] {
		REG_GPIO_IN     = 10'd0,
		REG_GPIO_OUT    = 10'd1,
		REG_GPIO_IRQ_EN = 10'd2,
		REG_SYSTEM_ID   = 10'd3
	} sysctl_reg_e;

	// "X401"
	localparam logic [DATA_W-1:0] SYSTEM_ID = 32'h58343031;

	// Switches and buttons in, LEDs and LCD out
	localparam int GPIO_IN_W  = 13;
	localparam int GPIO_OUT_W = 14;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [3:0] d;
	} lcd_t;

	// Activity hold counter width
	localparam int ACT_HOLD_W = 19;

endpackage

// ==== src/activity_led.sv ====
// Serial activity LED
`timescale 1ns/10ps

module activity_led #(
	parameter int HOLD_W = soc_pkg::ACT_HOLD_W
) (
	input  logic sys_clk,
	input  logic arst_n_i,
	input  logic line_i,
	output logic led_o
);

	logic              line_s1;
	logic              line_s2;
	logic [HOLD_W-1:0] hold_q;
	logic              led_q;

	// Line idles high, so sync flops come out of reset at one
	// Low level reloads the hold, then it counts down to zero
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			line_s1 <= 1'b1;
			line_s2 <= 1'b1;
			hold_q  <= '0;
			led_q   <= 1'b0;
		end else begin
			line_s1 <= line_i;
			line_s2 <= line_s1;
			if (!line_s2) begin
				hold_q <= '1;
			end else if (hold_q != '0) begin
				hold_q <= hold_q - 1'b1;
			end
			led_q <= (hold_q != '0);
		end
	end

	assign led_o = led_q;

endmodule

// ==== src/bram_slave.sv ====
// On-chip block RAM slave
`timescale 1ns/10ps

module bram_slave (
	input  logic              sys_clk,
	input  logic              arst_n_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);

	import soc_pkg::*;

	localparam int DEPTH = 2 ** BRAM_ADR_W;

	logic [DATA_W-1:0]     mem [DEPTH];
	logic [BRAM_ADR_W-1:0] word_adr;
	logic                  access;
	logic                  ack_q;
	logic [DATA_W-1:0]     rd_q;

	// Byte address in, word index into the array
	assign word_adr = req_i.adr[BRAM_ADR_W+1:2];

	// Held stb after ack is not a new access
	assign access = req_i.cyc & req_i.stb & ~ack_q;

	// --------------------
	// Storage
	// --------------------

	// Byte lanes written under sel, read word registered
	always_ff @(posedge sys_clk) begin
		if (access && req_i.we) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
		rd_q <= mem[word_adr];
	end

	// Ack one cycle after the access
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign rsp_o.dat = rd_q;
	assign rsp_o.ack = ack_q;

endmodule

// ==== src/bus_decoder.sv ====
// Bus address decoder
`timescale 1ns/10ps

module bus_decoder (
	input  logic              sys_clk,
	input  logic              arst_n_i,
	input  soc_pkg::bus_req_t m_req_i,
	output soc_pkg::bus_rsp_t m_rsp_o,
	output soc_pkg::bus_req_t bram_req_o,
	input  soc_pkg::bus_rsp_t bram_rsp_i,
	output soc_pkg::bus_req_t csr_req_o,
	input  soc_pkg::bus_rsp_t csr_rsp_i
);

	import soc_pkg::*;

	region_e region;
	logic    dflt_access;
	logic    dflt_ack_q;

	// --------------------
	// Region decode
	// --------------------

	// Top three address bits pick the slave
	always_comb begin
		case (m_req_i.adr[ADDR_W-1 -: 3])
			REGION_BRAM: region = REGION_BRAM;
			REGION_CSR:  region = REGION_CSR;
			default:     region = REGION_DEFAULT;
		endcase
	end

	// Request fields fan out unchanged
	// Only cyc and stb are gated per slave
	always_comb begin
		bram_req_o     = m_req_i;
		bram_req_o.cyc = m_req_i.cyc & (region == REGION_BRAM);
		bram_req_o.stb = m_req_i.stb & (region == REGION_BRAM);
		csr_req_o      = m_req_i;
		csr_req_o.cyc  = m_req_i.cyc & (region == REGION_CSR);
		csr_req_o.stb  = m_req_i.stb & (region == REGION_CSR);
	end

	// --------------------
	// Default region
	// --------------------

	// Unpopulated space, acked and never stored
	assign dflt_access = m_req_i.cyc & m_req_i.stb & (region == REGION_DEFAULT);

	// One ack per access, none while it is high
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dflt_ack_q <= 1'b0;
		end else begin
			dflt_ack_q <= dflt_access & ~dflt_ack_q;
		end
	end

	// --------------------
	// Response mux
	// --------------------

	always_comb begin
		case (region)
			REGION_BRAM: begin
				m_rsp_o = bram_rsp_i;
			end
			REGION_CSR: begin
				m_rsp_o = csr_rsp_i;
			end
			default: begin
				m_rsp_o.dat = DEFAULT_RD_DATA;
				m_rsp_o.ack = dflt_ack_q;
			end
		endcase
	end

endmodule

// ==== src/csr_bridge.sv ====
// Bus to CSR bridge
`timescale 1ns/10ps

module csr_bridge (
	input  logic                       sys_clk,
	input  logic                       arst_n_i,
	input  soc_pkg::bus_req_t          req_i,
	output soc_pkg::bus_rsp_t          rsp_o,
	output soc_pkg::csr_req_t          csr_o,
	input  logic [soc_pkg::DATA_W-1:0] csr_rd_i
);

	import soc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} state_e;

	state_e               state_q;
	logic                 ack_q;
	logic                 we_q;
	logic [CSR_ADR_W-1:0] a_q;
	logic [DATA_W-1:0]    dw_q;
	logic [DATA_W-1:0]    rd_q;

	// --------------------
	// Control FSM
	// --------------------

	// Idle -> address on CSR bus -> read word back -> ack
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_IDLE;
			ack_q   <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			we_q  <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					// Skip the cycle where our own ack is out
					if (req_i.cyc && req_i.stb && !ack_q) begin
						we_q    <= req_i.we;
						state_q <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					state_q <= ST_DATA;
				end
				default: begin
					ack_q   <= 1'b1;
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Word address bits become the CSR address
	always_ff @(posedge sys_clk) begin
		if (state_q == ST_IDLE) begin
			a_q  <= req_i.adr[CSR_ADR_W+1:2];
			dw_q <= req_i.dat;
		end
		if (state_q == ST_DATA) begin
			rd_q <= csr_rd_i;
		end
	end

	assign csr_o.a  = a_q;
	assign csr_o.we = we_q;
	assign csr_o.dw = dw_q;

	assign rsp_o.dat = rd_q;
	assign rsp_o.ack = ack_q;

endmodule

// ==== src/sysctl_regs.sv ====
// System controller registers
`timescale 1ns/10ps

module sysctl_regs (
	input  logic                           sys_clk,
	input  logic                           arst_n_i,
	input  soc_pkg::csr_req_t              csr_i,
	output logic [soc_pkg::DATA_W-1:0]     csr_rd_o,
	input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_in_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_out_o,
	output logic                           gpio_irq_o
);

	import soc_pkg::*;

	logic                  bank_sel;
	sysctl_reg_e           reg_sel;
	logic                  wr_en;

	logic [GPIO_IN_W-1:0]  gin_s1;
	logic [GPIO_IN_W-1:0]  gin_s2;
	logic [GPIO_IN_W-1:0]  gin_d;
	logic [GPIO_IN_W-1:0]  irq_en_q;
	logic [GPIO_OUT_W-1:0] gout_q;
	logic                  irq_q;
	logic [DATA_W-1:0]     rd_q;

	// --------------------
	// Address decode
	// --------------------

	// Bank in the top nibble
	assign bank_sel = (csr_i.a[CSR_ADR_W-1 -: 4] == CSR_BANK_SYSCTL);
	assign reg_sel  = sysctl_reg_e'(csr_i.a[9:0]);
	assign wr_en    = bank_sel & csr_i.we;

	// --------------------
	// GPIO inputs
	// --------------------

	// Two-flop sync, third flop keeps last value for edge detect
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			gin_s1 <= '0;
			gin_s2 <= '0;
			gin_d  <= '0;
			irq_q  <= 1'b0;
		end else begin
			gin_s1 <= gpio_in_i;
			gin_s2 <= gin_s1;
			gin_d  <= gin_s2;
			// Any enabled bit that toggled
			irq_q  <= |((gin_s2 ^ gin_d) & irq_en_q);
		end
	end

	// --------------------
	// Writable registers
	// --------------------

	// Read-only indices fall to default and are dropped
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			gout_q   <= '0;
			irq_en_q <= '0;
		end else if (wr_en) begin
			case (reg_sel)
				REG_GPIO_OUT:    gout_q   <= csr_i.dw[GPIO_OUT_W-1:0];
				REG_GPIO_IRQ_EN: irq_en_q <= csr_i.dw[GPIO_IN_W-1:0];
				default:         ;
			endcase
		end
	end

	// --------------------
	// Read path
	// --------------------

	// Zero outside our bank so it can be ORed with others
	always_ff @(posedge sys_clk) begin
		rd_q <= '0;
		if (bank_sel) begin
			case (reg_sel)
				REG_GPIO_IN:     rd_q <= {{(DATA_W-GPIO_IN_W){1'b0}}, gin_s2};
				REG_GPIO_OUT:    rd_q <= {{(DATA_W-GPIO_OUT_W){1'b0}}, gout_q};
				REG_GPIO_IRQ_EN: rd_q <= {{(DATA_W-GPIO_IN_W){1'b0}}, irq_en_q};
				REG_SYSTEM_ID:   rd_q <= SYSTEM_ID;
				default:         rd_q <= '0;
			endcase
		end
	end

	assign csr_rd_o   = rd_q;
	assign gpio_out_o = gout_q;
	assign gpio_irq_o = irq_q;

endmodule

// ==== src/soc_top.sv ====
// SoC top level
`timescale 1ns/10ps

module soc_top (
	input  logic                          sys_clk,
	input  logic                          arst_n_i,
	input  soc_pkg::bus_req_t             bus_req_i,
	output soc_pkg::bus_rsp_t             bus_rsp_o,
	input  logic [soc_pkg::GPIO_IN_W-1:0] gpio_in_i,
	input  logic                          uart_rxd_i,
	output logic [2:0]                    led_o,
	output logic [4:0]                    btnled_o,
	output soc_pkg::lcd_t                 lcd_o,
	output logic                          gpio_irq_o
);

	import soc_pkg::*;

	bus_req_t              bram_req;
	bus_rsp_t              bram_rsp;
	bus_req_t              csrbrg_req;
	bus_rsp_t              csrbrg_rsp;
	csr_req_t              csr_req;
	logic [DATA_W-1:0]     csr_rd;
	logic [GPIO_OUT_W-1:0] gpio_out;
	logic                  rx_led;

	// --------------------
	// Bus fabric
	// --------------------

	bus_decoder u_decoder (
		.sys_clk    (sys_clk),
		.arst_n_i   (arst_n_i),
		.m_req_i    (bus_req_i),
		.m_rsp_o    (bus_rsp_o),
		.bram_req_o (bram_req),
		.bram_rsp_i (bram_rsp),
		.csr_req_o  (csrbrg_req),
		.csr_rsp_i  (csrbrg_rsp)
	);

	// 0x20000000
	bram_slave u_bram (
		.sys_clk  (sys_clk),
		.arst_n_i (arst_n_i),
		.req_i    (bram_req),
		.rsp_o    (bram_rsp)
	);

	// 0x80000000
	csr_bridge u_csrbrg (
		.sys_clk  (sys_clk),
		.arst_n_i (arst_n_i),
		.req_i    (csrbrg_req),
		.rsp_o    (csrbrg_rsp),
		.csr_o    (csr_req),
		.csr_rd_i (csr_rd)
	);

	// --------------------
	// Peripherals
	// --------------------

	sysctl_regs u_sysctl (
		.sys_clk    (sys_clk),
		.arst_n_i   (arst_n_i),
		.csr_i      (csr_req),
		.csr_rd_o   (csr_rd),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out),
		.gpio_irq_o (gpio_irq_o)
	);

	activity_led u_rx_led (
		.sys_clk  (sys_clk),
		.arst_n_i (arst_n_i),
		.line_i   (uart_rxd_i),
		.led_o    (rx_led)
	);

	// LED 0 shows RX activity, the rest come from GPIO
	assign led_o    = {gpio_out[1:0], rx_led};
	assign btnled_o = gpio_out[6:2];
	assign lcd_o.e  = gpio_out[7];
	assign lcd_o.rs = gpio_out[8];
	assign lcd_o.rw = gpio_out[9];
	assign lcd_o.d  = gpio_out[13:10];

endmodule

// ==== verif/soc_tb.sv ====
// SoC testbench
`timescale 1ns/10ps

module soc_tb;

	import soc_pkg::*;

	localparam int BUS_TIMEOUT = 20;
	localparam int LED_HOLD    = 2 ** ACT_HOLD_W - 1;

	logic                  sys_clk;
	logic                  arst_n_i;
	bus_req_t              bus_req;
	bus_rsp_t              bus_rsp;
	logic [GPIO_IN_W-1:0]  gpio_in;
	logic                  uart_rxd;
	logic [2:0]            led;
	logic [4:0]            btnled;
	lcd_t                  lcd;
	logic                  gpio_irq;

	logic [15:0]           lfsr_q;
	int                    value_errs;
	int                    other_errs;
	// Reference state
	logic [DATA_W-1:0]     shadow [2 ** BRAM_ADR_W];
	logic [GPIO_OUT_W-1:0] gout_ref;
	logic [GPIO_IN_W-1:0]  irq_en_ref;

	soc_top dut0 (
		.sys_clk    (sys_clk),
		.arst_n_i   (arst_n_i),
		.bus_req_i  (bus_req),
		.bus_rsp_o  (bus_rsp),
		.gpio_in_i  (gpio_in),
		.uart_rxd_i (uart_rxd),
		.led_o      (led),
		.btnled_o   (btnled),
		.lcd_o      (lcd),
		.gpio_irq_o (gpio_irq)
	);

	always #5 sys_clk = ~sys_clk;

	// --------------------
	// Stimulus helpers
	// --------------------

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [ADDR_W-1:0] csr_addr(input logic [3:0] bank,
		input logic [9:0] idx);
		return 32'h8000_0000 | {bank, idx, 2'b00};
	endfunction

	// --------------------
	// Reference model
	// --------------------

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = wdat[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] adr);
		case (adr[31:29])
			3'b001: return shadow[adr[13:2]];
			3'b100: begin
				// Other banks read as zero
				if (adr[15:12] != 4'h1) begin
					return '0;
				end
				case (adr[11:2])
					10'd0:   return {19'd0, gpio_in};
					10'd1:   return {18'd0, gout_ref};
					10'd2:   return {19'd0, irq_en_ref};
					10'd3:   return 32'h5834_3031;
					default: return '0;
				endcase
			end
			default: return 32'hABAD_FACE;
		endcase
	endfunction

	// CSR side ignores byte selects
	function automatic void model_write(input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel);
		if (adr[31:29] == 3'b001) begin
			shadow[adr[13:2]] = merge_bytes(shadow[adr[13:2]], wdat, sel);
		end else if (adr[31:29] == 3'b100 && adr[15:12] == 4'h1) begin
			if (adr[11:2] == 10'd1) begin
				gout_ref = wdat[13:0];
			end else if (adr[11:2] == 10'd2) begin
				irq_en_ref = wdat[12:0];
			end
		end
	endfunction

	// --------------------
	// Compare tasks
	// --------------------

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// Bits 1:0 to LEDs, 6:2 to button LEDs, 13:7 to the LCD
	task automatic check_gpio(input logic [GPIO_OUT_W-1:0] v);
		lcd_t exp_lcd;
		exp_lcd.e  = v[7];
		exp_lcd.rs = v[8];
		exp_lcd.rw = v[9];
		exp_lcd.d  = v[13:10];
		if ({led[2:1], btnled, lcd} !== {v[1:0], v[6:2], exp_lcd}) begin
			value_errs++;
			$display("CHECK FAILED led_o[2:1]/btnled_o/lcd_o got %h expected %h",
				{led[2:1], btnled, lcd}, {v[1:0], v[6:2], exp_lcd});
		end
	endtask

	// --------------------
	// Bus tasks
	// --------------------

	// Drive after the edge, sample ack and data at the falling edge
	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel,
		output logic [DATA_W-1:0] rdata);
		int n;
		@(posedge sys_clk);
		#1;
		bus_req.adr = adr;
		bus_req.dat = wdat;
		bus_req.sel = sel;
		bus_req.we  = we;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		n = 0;
		@(negedge sys_clk);
		while (!bus_rsp.ack && n < BUS_TIMEOUT) begin
			n++;
			@(negedge sys_clk);
		end
		if (!bus_rsp.ack) begin
			other_errs++;
			$display("bus access to address %h was never acknowledged", adr);
		end
		rdata = bus_rsp.dat;
		@(posedge sys_clk);
		#1;
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
		bus_req.we  = 1'b0;
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat,
		input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] unused;
		bus_access(1'b1, adr, wdat, sel, unused);
		model_write(adr, wdat, sel);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdata);
		bus_access(1'b0, adr, '0, 4'hF, rdata);
	endtask

	task automatic read_and_compare(input logic [ADDR_W-1:0] adr);
		logic [DATA_W-1:0] got;
		bus_read(adr, got);
		check_word($sformatf("bus_rsp_o.dat @ %h", adr), got, expected_read(adr));
	endtask

	// Counts irq pulses over a short window after one input toggle
	task automatic toggle_input(input int idx, output int pulses);
		@(posedge sys_clk);
		#1;
		gpio_in[idx] = ~gpio_in[idx];
		pulses = 0;
		repeat (8) begin
			@(negedge sys_clk);
			if (gpio_irq) begin
				pulses++;
			end
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		logic [31:0] adr;
		logic [11:0] words [$];
		int          pulses;
		int          n;
		sys_clk    = 1'b0;
		arst_n_i   = 1'b0;
		bus_req    = '0;
		gpio_in    = '0;
		uart_rxd   = 1'b1;
		lfsr_q     = 16'd86;
		value_errs = 0;
		other_errs = 0;
		gout_ref   = '0;
		irq_en_ref = '0;
		repeat (16) @(posedge sys_clk);
		#1;
		arst_n_i = 1'b1;
		@(negedge sys_clk);
		check_bit("bus_rsp_o.ack", bus_rsp.ack, 1'b0);
		check_bit("gpio_irq_o", gpio_irq, 1'b0);
		check_bit("led_o[0]", led[0], 1'b0);
		check_gpio('0);

		// Full word first so partial writes merge into known bytes
		for (int i = 0; i < 24; i++) begin
			draw_bits(BRAM_ADR_W, rnd);
			words.push_back(rnd[11:0]);
			adr = 32'h2000_0000 | {rnd[11:0], 2'b00};
			draw_bits(32, data);
			bus_write(adr, data, 4'hF);
			draw_bits(4, rnd);
			draw_bits(32, data);
			bus_write(adr, data, rnd[3:0]);
		end
		foreach (words[i]) begin
			read_and_compare(32'h2000_0000 | {words[i], 2'b00});
		end

		// Unmapped regions alias the same low bits as a BRAM word
		adr = 32'h2000_0000 | {words[0], 2'b00};
		for (int r = 0; r < 8; r++) begin
			if (r != 1 && r != 4) begin
				read_and_compare({r[2:0], adr[28:0]});
				draw_bits(32, data);
				bus_write({r[2:0], adr[28:0]}, data, 4'hF);
			end
		end
		read_and_compare(adr);

		// Read-only registers and a foreign bank
		draw_bits(32, data);
		bus_write(csr_addr(4'h1, 10'd3), data, 4'hF);
		bus_write(csr_addr(4'h1, 10'd0), data, 4'hF);
		bus_write(csr_addr(4'h2, 10'd1), data, 4'hF);
		read_and_compare(csr_addr(4'h1, 10'd3));
		read_and_compare(csr_addr(4'h1, 10'd0));
		read_and_compare(csr_addr(4'h2, 10'd3));
		read_and_compare(csr_addr(4'h1, 10'd1));

		// Output pins and input sync
		for (int i = 0; i < 4; i++) begin
			draw_bits(GPIO_OUT_W, data);
			bus_write(csr_addr(4'h1, 10'd1), data, 4'hF);
			check_gpio(gout_ref);
			read_and_compare(csr_addr(4'h1, 10'd1));
			draw_bits(GPIO_IN_W, data);
			gpio_in = data[GPIO_IN_W-1:0];
			repeat (3) @(posedge sys_clk);
			read_and_compare(csr_addr(4'h1, 10'd0));
		end

		// Only bit 3 enabled
		bus_write(csr_addr(4'h1, 10'd2), 32'h8, 4'hF);
		read_and_compare(csr_addr(4'h1, 10'd2));
		toggle_input(3, pulses);
		check_word("gpio_irq_o pulses, enabled bit", pulses, 1);
		toggle_input(5, pulses);
		check_word("gpio_irq_o pulses, disabled bit", pulses, 0);

		// RX activity LED on, then hold after the line returns high
		@(posedge sys_clk);
		#1;
		uart_rxd = 1'b0;
		n = 0;
		@(negedge sys_clk);
		while (!led[0] && n < 4) begin
			n++;
			@(negedge sys_clk);
		end
		check_bit("led_o[0] after rxd low", led[0], 1'b1);
		@(posedge sys_clk);
		#1;
		uart_rxd = 1'b1;
		n = 0;
		@(negedge sys_clk);
		while (led[0] && n < LED_HOLD + 16) begin
			n++;
			@(negedge sys_clk);
		end
		if (n < LED_HOLD - 4 || n > LED_HOLD + 4) begin
			other_errs++;
			$display("activity LED went dark after %0d cycles instead of about %0d",
				n, LED_HOLD);
		end

		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
src/soc_pkg.sv
src/activity_led.sv
src/bram_slave.sv
src/bus_decoder.sv
src/csr_bridge.sv
src/sysctl_regs.sv
src/soc_top.sv
verif/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc

sources:
  - files:
      - src/soc_pkg.sv
      - src/activity_led.sv
      - src/bram_slave.sv
      - src/bus_decoder.sv
      - src/csr_bridge.sv
      - src/sysctl_regs.sv
      - src/soc_top.sv
  - target: simulation
    files:
      - verif/soc_tb.sv
